//--- dmem_pkg.sv
package dmem_pkg;

    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int MASK_WIDTH = DATA_WIDTH / 8;

    // loads first, then stores
    typedef enum logic [2:0] {
        LB,
        LBU,
        LH,
        LHU,
        LW,
        SB,
        SH,
        SW
    } mem_opcode_t;

    // one operation as issued by the pipeline, 67 bits
    typedef struct packed {
        mem_opcode_t             opcode;
        logic [ADDR_WIDTH-1:0]   addr;  // byte address
        logic [DATA_WIDTH-1:0]   data;  // store data, low bits used for SB/SH
    } mem_op_t;

    // memory port request, 72 bits
    typedef struct packed {
        logic [ADDR_WIDTH-1:0]   addr;  // word aligned
        logic [MASK_WIDTH-1:0]   rmask;
        logic [MASK_WIDTH-1:0]   wmask;
        logic [DATA_WIDTH-1:0]   wdata; // already in its byte lanes
    } mem_req_t;

    // a request counts only while one of its masks is set
    function automatic logic req_valid(input mem_req_t req);
        return (req.rmask != '0) || (req.wmask != '0);
    endfunction

    function automatic logic is_store(input mem_opcode_t opc);
        return opc inside {SB, SH, SW};
    endfunction

    function automatic logic is_load(input mem_opcode_t opc);
        return opc inside {LB, LBU, LH, LHU, LW};
    endfunction

endpackage

//--- mem_stage.sv
`timescale 1ns/1ps

module mem_stage import dmem_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  op_valid,
    input  mem_op_t               op,
    output logic                  op_ready,
    output mem_req_t              cpu_req,
    input  logic                  ufp_resp,
    input  logic [DATA_WIDTH-1:0] ufp_rdata,
    output logic                  load_valid,
    output logic [DATA_WIDTH-1:0] load_data
);

    typedef enum logic {
        IDLE,
        WAIT
    } state_t;

    state_t                state;
    mem_opcode_t           pend_op;
    logic [1:0]            pend_off;
    logic                  accept;
    logic [MASK_WIDTH-1:0] size_mask;
    logic [MASK_WIDTH-1:0] lane_mask;
    logic [DATA_WIDTH-1:0] rdata_shifted;

    // a new op may enter in the same cycle the pending one is answered
    assign op_ready = (state == IDLE) || ufp_resp;
    assign accept   = op_valid && op_ready;

    always_comb begin
        case (op.opcode)
            LB, LBU, SB: size_mask = 4'b0001;
            LH, LHU, SH: size_mask = 4'b0011;
            default:     size_mask = 4'b1111;
        endcase
        lane_mask = size_mask << op.addr[1:0];

        cpu_req = '0; // masks stay zero unless an op is taken this cycle
        if (accept) begin
            cpu_req.addr = {op.addr[ADDR_WIDTH-1:2], 2'b00};
            if (is_store(op.opcode)) begin
                cpu_req.wmask = lane_mask;
                cpu_req.wdata = op.data << {op.addr[1:0], 3'b000};
            end else begin
                cpu_req.rmask = lane_mask;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: if (accept) state <= WAIT;
                WAIT: if (ufp_resp && !accept) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // opcode and offset of the outstanding access
    always_ff @(posedge clk) begin
        if (accept) begin
            pend_op  <= op.opcode;
            pend_off <= op.addr[1:0];
        end
    end

    assign rdata_shifted = ufp_rdata >> {pend_off, 3'b000};
    assign load_valid    = (state == WAIT) && ufp_resp && is_load(pend_op);

    always_comb begin
        case (pend_op)
            LB:      load_data = {{24{rdata_shifted[7]}}, rdata_shifted[7:0]};
            LBU:     load_data = {24'h0, rdata_shifted[7:0]};
            LH:      load_data = {{16{rdata_shifted[15]}}, rdata_shifted[15:0]};
            LHU:     load_data = {16'h0, rdata_shifted[15:0]};
            LW:      load_data = ufp_rdata;
            default: load_data = '0;
        endcase
    end

    // misaligned accesses are not supported by the memory path
    assert property (@(posedge clk) disable iff (rst)
        accept && (op.opcode inside {LH, LHU, SH}) |-> (op.addr[0] == 1'b0));

    assert property (@(posedge clk) disable iff (rst)
        accept && (op.opcode inside {LW, SW}) |-> (op.addr[1:0] == 2'b00));

endmodule

//--- dcache_req_hold.sv
`timescale 1ns/1ps

module dcache_req_hold import dmem_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  mem_req_t cpu_req,
    input  logic     ufp_resp,
    output mem_req_t ufp_req
);

    mem_req_t held;
    logic     held_valid;
    logic     cpu_valid;
    logic     pass_through;

    assign held_valid   = req_valid(held);
    assign cpu_valid    = req_valid(cpu_req);
    assign pass_through = !held_valid && cpu_valid; // idle, show new request at once

    always_ff @(posedge clk) begin
        if (rst) begin
            held <= '0;
        end else if (ufp_resp) begin
            // response ends the held request, pick up a follow-on if one is there
            if (cpu_valid) begin
                held <= cpu_req;
            end else begin
                held <= '0;
            end
        end else if (pass_through) begin
            held <= cpu_req;
        end
    end

    always_comb begin
        if (pass_through) begin
            ufp_req = cpu_req;
        end else begin
            ufp_req = held;
        end
    end

    // memory sees a stable request from first appearance until it answers
    assert property (@(posedge clk) disable iff (rst)
        req_valid(ufp_req) && !ufp_resp |=> ufp_req == $past(ufp_req));

endmodule

//--- dmem_responder.sv
`timescale 1ns/1ps

module dmem_responder import dmem_pkg::*; #(
    parameter int unsigned DEPTH_WORDS = 256,
    parameter int unsigned MAX_WAIT    = 3
) (
    input  logic                  clk,
    input  logic                  rst,
    input  mem_req_t              ufp_req,
    output logic                  ufp_resp,
    output logic [DATA_WIDTH-1:0] ufp_rdata
);

    localparam int IDX_W = $clog2(DEPTH_WORDS);
    localparam int CNT_W = $clog2(MAX_WAIT + 2);

    if ((DEPTH_WORDS & (DEPTH_WORDS - 1)) != 0) begin : g_depth_check
        $error("DEPTH_WORDS must be a power of two");
    end

    logic [DATA_WIDTH-1:0] mem [DEPTH_WORDS];
    logic [IDX_W-1:0]      idx;
    logic                  busy;       // request seen, response not yet given
    logic [CNT_W-1:0]      wait_cnt;
    logic [15:0]           lfsr;
    logic                  lfsr_fb;

    assign idx       = ufp_req.addr[IDX_W+1:2]; // wraps modulo depth
    assign lfsr_fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    assign ufp_resp  = busy && (wait_cnt == '0);
    assign ufp_rdata = mem[idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            wait_cnt <= '0;
            lfsr     <= 16'hace1;
            for (int i = 0; i < DEPTH_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else begin
            lfsr <= {lfsr[14:0], lfsr_fb}; // free running
            if (!busy) begin
                if (req_valid(ufp_req)) begin
                    busy     <= 1'b1;
                    wait_cnt <= CNT_W'(lfsr % (MAX_WAIT + 1));
                end
            end else if (ufp_resp) begin
                busy <= 1'b0;
                for (int b = 0; b < MASK_WIDTH; b++) begin
                    if (ufp_req.wmask[b]) begin
                        mem[idx][8*b +: 8] <= ufp_req.wdata[8*b +: 8];
                    end
                end
            end else begin
                wait_cnt <= wait_cnt - 1'b1;
            end
        end
    end

    // holder must keep the request up through the response cycle
    assert property (@(posedge clk) disable iff (rst)
        ufp_resp |-> req_valid(ufp_req));

endmodule

//--- dmem_top.sv
`timescale 1ns/1ps

module dmem_top import dmem_pkg::*; #(
    parameter int unsigned DEPTH_WORDS = 256,
    parameter int unsigned MAX_WAIT    = 3
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  op_valid,
    input  mem_op_t               op,
    output logic                  op_ready,
    output logic                  load_valid,
    output logic [DATA_WIDTH-1:0] load_data
);

    mem_req_t              cpu_req;
    mem_req_t              ufp_req;
    logic                  ufp_resp;
    logic [DATA_WIDTH-1:0] ufp_rdata;

    mem_stage u_mem_stage (
        .clk        (clk),
        .rst        (rst),
        .op_valid   (op_valid),
        .op         (op),
        .op_ready   (op_ready),
        .cpu_req    (cpu_req),
        .ufp_resp   (ufp_resp),
        .ufp_rdata  (ufp_rdata),
        .load_valid (load_valid),
        .load_data  (load_data)
    );

    dcache_req_hold u_req_hold (
        .clk      (clk),
        .rst      (rst),
        .cpu_req  (cpu_req),
        .ufp_resp (ufp_resp),
        .ufp_req  (ufp_req)
    );

    dmem_responder #(
        .DEPTH_WORDS (DEPTH_WORDS),
        .MAX_WAIT    (MAX_WAIT)
    ) u_dmem (
        .clk       (clk),
        .rst       (rst),
        .ufp_req   (ufp_req),
        .ufp_resp  (ufp_resp),
        .ufp_rdata (ufp_rdata)
    );

endmodule

//--- tb_dmem_top.sv
`timescale 1ns/1ps

module tb_dmem_top import dmem_pkg::*; ();

    localparam int          NUM_OPS        = 400;
    localparam int          MAX_WAIT       = 3;   // matches the dmem_top default
    localparam int          RESET_CYCLES   = 16;
    localparam int          TIMEOUT_CYCLES = RESET_CYCLES + NUM_OPS * (2 + MAX_WAIT) + 100;
    localparam logic [31:0] SEED           = 32'h709d;

    logic                  clk;
    logic                  rst;
    logic                  op_valid;
    mem_op_t               op;
    logic                  op_ready;
    logic                  load_valid;
    logic [DATA_WIDTH-1:0] load_data;

    logic [7:0]  model [256];  // byte image of the low 64 words
    logic [31:0] exp_q [$];    // expected load results, oldest first
    logic        took_op;      // op accepted in the cycle just sampled
    logic        ready_checked;
    int          issued;
    int          accepted_cnt;
    int          loads_accepted;
    int          loads_seen;
    int          stores_accepted;
    int          cycle_cnt;

    dmem_top u_dut (
        .clk        (clk),
        .rst        (rst),
        .op_valid   (op_valid),
        .op         (op),
        .op_ready   (op_ready),
        .load_valid (load_valid),
        .load_data  (load_data)
    );

    always #50 clk = ~clk;

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("[FAIL] %0t ns %s got 0x%h expected 0x%h",
                                        $time, name, got, exp));
        end
    endtask

    function automatic mem_op_t random_op();
        mem_op_t    o;
        logic [5:0] word;
        logic [1:0] off;
        o.opcode = mem_opcode_t'($urandom_range(0, 7));
        word     = 6'($urandom_range(0, 63));
        case (o.opcode)
            LB, LBU, SB: off = 2'($urandom_range(0, 3));
            LH, LHU, SH: off = {1'($urandom_range(0, 1)), 1'b0};
            default:     off = 2'b00;
        endcase
        o.addr = {24'h0, word, off};
        o.data = $urandom;
        return o;
    endfunction

    // little endian: byte at offset k lives in lane k
    function automatic logic [31:0] expected_load(input mem_opcode_t opc, input int a);
        logic [7:0]  b;
        logic [15:0] h;
        b = model[a];
        h = {model[(a + 1) % 256], model[a]};
        case (opc)
            LB:      return {{24{b[7]}}, b};
            LBU:     return {24'h0, b};
            LH:      return {{16{h[15]}}, h};
            LHU:     return {16'h0, h};
            default: return {model[(a + 3) % 256], model[(a + 2) % 256], h};
        endcase
    endfunction

    task automatic apply_op(input mem_op_t o);
        int a;
        a = int'(o.addr[7:0]);
        case (o.opcode)
            SB: begin
                model[a]        = o.data[7:0];
                stores_accepted = stores_accepted + 1;
            end
            SH: begin
                model[a]        = o.data[7:0];
                model[a + 1]    = o.data[15:8];
                stores_accepted = stores_accepted + 1;
            end
            SW: begin
                for (int i = 0; i < 4; i++) begin
                    model[a + i] = o.data[8*i +: 8];
                end
                stores_accepted = stores_accepted + 1;
            end
            default: begin
                exp_q.push_back(expected_load(o.opcode, a));
                loads_accepted = loads_accepted + 1;
            end
        endcase
        accepted_cnt = accepted_cnt + 1;
    endtask

    task automatic check_load();
        logic [31:0] exp;
        if (exp_q.size() == 0) begin
            stop_with_failure("load_valid pulsed while no load was outstanding");
        end else begin
            exp        = exp_q.pop_front();
            loads_seen = loads_seen + 1;
            check_value("load_data", load_data, exp);
        end
    endtask

    // hold each op until it is taken, sometimes leave a bubble
    always @(posedge clk) begin
        if (rst) begin
            op_valid <= 1'b0;
        end else if (!op_valid || took_op) begin
            if (issued == NUM_OPS) begin
                op_valid <= 1'b0;
            end else if ($urandom_range(0, 7) == 0) begin
                op_valid <= 1'b0;
            end else begin
                op       <= random_op();
                op_valid <= 1'b1;
                issued   <= issued + 1;
            end
        end
    end

    // sample mid-cycle where everything is settled
    always @(negedge clk) begin
        if (rst) begin
            took_op = 1'b0;
        end else begin
            if (!ready_checked) begin
                check_value("op_ready", 32'(op_ready), 32'd1);
                ready_checked = 1'b1;
            end
            if (load_valid) begin
                check_load(); // older load answered before the new one is booked
            end
            took_op = op_valid && op_ready;
            if (took_op) begin
                apply_op(op);
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            stop_with_failure($sformatf("timeout: operations did not complete, %0d of %0d accepted",
                                        accepted_cnt, NUM_OPS));
        end
    end

    initial begin
        void'($urandom(SEED));
        clk             = 1'b0;
        rst             = 1'b1;
        op_valid        = 1'b0;
        op              = '0;
        took_op         = 1'b0;
        ready_checked   = 1'b0;
        issued          = 0;
        accepted_cnt    = 0;
        loads_accepted  = 0;
        loads_seen      = 0;
        stores_accepted = 0;
        cycle_cnt       = 0;
        for (int i = 0; i < 256; i++) begin
            model[i] = 8'h00;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        wait (accepted_cnt == NUM_OPS);
        repeat (2 * (2 + MAX_WAIT)) @(posedge clk); // last op drains, then room for a stray strobe
        @(negedge clk);

        $display("ops %0d, loads %0d, stores %0d, cycles %0d",
                 accepted_cnt, loads_accepted, stores_accepted, cycle_cnt);
        if (exp_q.size() != 0) begin
            stop_with_failure($sformatf("%0d of %0d accepted loads never returned a result",
                                        exp_q.size(), loads_accepted));
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

//--- files.f
dmem_pkg.sv
mem_stage.sv
dcache_req_hold.sv
dmem_responder.sv
dmem_top.sv
tb_dmem_top.sv
